//--- Makefile
SRCS := $(filter %.sv,$(shell cat conv_ctrl.f)) conv_ctrl_config.svh

obj_dir/Vtb_conv_ctrl: $(SRCS) conv_ctrl.f
	verilator --binary --timing -f conv_ctrl.f --top-module tb_conv_ctrl

run: obj_dir/Vtb_conv_ctrl
	./obj_dir/Vtb_conv_ctrl | tee sim.log
	grep -q "^PASS: all tests$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- conv_ctrl.f
+incdir+.
conv_ctrl_pkg.sv
image_read_sequencer.sv
image_write_sequencer.sv
stage_gate.sv
frame_tracker.sv
conv_ctrl_top.sv
conv_ctrl_checker.sv
tb_conv_ctrl.sv

//--- conv_ctrl_checker.sv
`timescale 1ns/1ps

`include "conv_ctrl_config.svh"

module conv_ctrl_checker (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic                                         start_read,
    input  logic                                         write_pixel_ready,
    input  logic                     [`CC_NUM_STAGES-1:0] maxpool_done,
    input  logic                     [`CC_NUM_STAGES-1:0] fifo_empty,
    input  conv_ctrl_pkg::shift_t    [`CC_NUM_STAGES-1:0] shift_count,
    input  logic                     [`CC_NUM_STAGES-1:0] start_mac,
    input  logic                     [`CC_NUM_STAGES-1:0] fill_window_ready,
    input  logic                     [`CC_NUM_STAGES-1:0] update_window_ready,
    input  conv_ctrl_pkg::wch_t      [`CC_NUM_STAGES-1:0] weight_channel,
    input  logic                                         bram_read_en,
    input  conv_ctrl_pkg::abs_addr_t                     bram_read_addr,
    input  logic                                         pe_valid_in,
    input  logic                                         pe_next_channel,
    input  logic                                         first_stage_enable,
    input  logic                                         read_done,
    input  logic                                         bank_select,
    input  logic                                         bram_write_en,
    input  conv_ctrl_pkg::abs_addr_t                     bram_write_addr,
    input  logic                     [`CC_NUM_STAGES-1:0] stage_enable,
    input  logic                     [`CC_NUM_STAGES-1:0] rd_ready,
    input  logic                                         frame_done,
    input  logic                                         end_of_test,
    output int                                           error_count
);

    localparam int N          = `CC_NUM_STAGES;
    localparam int IMG_PIXELS = `CC_IMAGE_WIDTH * `CC_IMAGE_HEIGHT;
    // enabled reads in one pass and writes in one burst
    localparam int PASS_READS = `CC_NUM_IMAGES * IMG_PIXELS;
    localparam int NEAR_END   = `CC_STAGE_ROWS - `CC_KERNEL_SIZE;
    localparam int CH_LAST    = `CC_IN_CHANNELS - 1;

    // behavior ids for the error counters
    localparam int T_READ_ORDER = 0;
    localparam int T_READ_DONE  = 1;
    localparam int T_WRITE      = 2;
    localparam int T_ENABLE     = 3;
    localparam int T_RDREADY    = 4;
    localparam int T_FRAME      = 5;
    localparam int NUM_TESTS    = 6;

    int cycle = 0;
    int err_cnt [NUM_TESTS] = '{default: 0};
    int other_errs = 0;
    int total_errs = 0;

    // read model keeps the pass position as one linear count
    logic m_read_active;
    int   m_reads;
    logic m_read_done;
    logic m_done_q;
    logic m_bank;
    logic m_fse;
    int   read_passes = 0;
    // write model
    logic m_write_active;
    int   m_waddr;
    int   dut_burst_len;
    int   write_bursts = 0;
    // stage latches and frame counter
    logic [N-1:0] m_rd_ready;
    int   m_frame_cnt;
    logic m_frame_done;
    int   frames_seen = 0;

    assign error_count = total_errs;

    function automatic string test_name(input int id);
        case (id)
            T_READ_ORDER: return "read_order";
            T_READ_DONE:  return "read_done_bank";
            T_WRITE:      return "write_burst";
            T_ENABLE:     return "stage_enable";
            T_RDREADY:    return "rd_ready";
            default:      return "frame_done";
        endcase
    endfunction

    task automatic check_value(input int id, input int exp_val, input int act_val);
        if (exp_val != act_val) begin
            $display("Fail %s at cycle %0d: expected %0d, actual %0d",
                     test_name(id), cycle, exp_val, act_val);
            err_cnt[id]++;
            total_errs++;
        end
    endtask

    task automatic count_other();
        other_errs++;
        total_errs++;
    endtask

    task automatic reset_model();
        m_read_active  = 1'b0;
        m_reads        = 0;
        m_read_done    = 1'b0;
        m_done_q       = 1'b0;
        m_bank         = 1'b0;
        m_fse          = 1'b0;
        m_write_active = 1'b0;
        m_waddr        = 0;
        dut_burst_len  = 0;
        m_rd_ready     = '0;
        m_frame_cnt    = 0;
        m_frame_done   = 1'b0;
    endtask

    // ----------------------------------------
    // read sequencer
    // ----------------------------------------

    task automatic step_read();
        logic exp_en;
        int   img;
        int   pix;
        // image index innermost
        img    = m_reads % `CC_NUM_IMAGES;
        pix    = m_reads / `CC_NUM_IMAGES;
        exp_en = m_read_active && start_read && !m_read_done;
        check_value(T_READ_ORDER, 32'(exp_en), 32'(bram_read_en));
        check_value(T_READ_ORDER, 32'(exp_en), 32'(pe_valid_in));
        check_value(T_READ_ORDER, 32'(exp_en && img == `CC_NUM_IMAGES - 1),
                    32'(pe_next_channel));
        if (exp_en) begin
            check_value(T_READ_ORDER, img * IMG_PIXELS + pix, 32'(bram_read_addr));
        end
        check_value(T_READ_DONE, 32'(m_read_done), 32'(read_done));
        check_value(T_READ_DONE, 32'(m_bank), 32'(bank_select));
        check_value(T_READ_DONE, 32'(m_fse), 32'(first_stage_enable));
        // next state from pre-edge values
        if (m_read_done && !m_done_q) m_bank = !m_bank;
        m_done_q = m_read_done;
        if (exp_en) m_fse = 1'b1;
        if (!m_read_active) begin
            if (start_read) begin
                m_read_active = 1'b1;
                m_reads       = 0;
                m_read_done   = 1'b0;
            end
        end else if (m_read_done) begin
            m_read_active = 1'b0;
        end else if (exp_en) begin
            m_reads++;
            if (m_reads == PASS_READS) begin
                m_read_done = 1'b1;
                read_passes++;
            end
        end
    endtask

    // ----------------------------------------
    // write sequencer
    // ----------------------------------------

    task automatic step_write();
        check_value(T_WRITE, 32'(m_write_active), 32'(bram_write_en));
        if (m_write_active) check_value(T_WRITE, m_waddr, 32'(bram_write_addr));
        // burst length as the DUT produced it
        if (bram_write_en) begin
            dut_burst_len++;
        end else if (dut_burst_len != 0) begin
            if (dut_burst_len != PASS_READS) begin
                $display("write burst lasted %0d cycles instead of %0d",
                         dut_burst_len, PASS_READS);
                count_other();
            end
            dut_burst_len = 0;
        end
        if (!m_write_active) begin
            if (write_pixel_ready) begin
                m_write_active = 1'b1;
                m_waddr        = 0;
            end
        end else if (m_waddr == PASS_READS - 1) begin
            m_write_active = 1'b0;
            write_bursts++;
        end else begin
            m_waddr++;
        end
    endtask

    // ----------------------------------------
    // stage gates and frame tracker
    // ----------------------------------------

    task automatic step_stages();
        logic [N:0] up_vec;
        logic       exp_en;
        int         sc;
        // stage 0 waits on the first read, others on the previous pool
        up_vec = {maxpool_done, m_fse};
        for (int k = 0; k < N; k++) begin
            sc     = 32'(shift_count[k]);
            exp_en = up_vec[k] || (!fifo_empty[k] && sc >= NEAR_END) || (sc == NEAR_END + 1);
            check_value(T_ENABLE, 32'(exp_en), 32'(stage_enable[k]));
            check_value(T_RDREADY, 32'(m_rd_ready[k]), 32'(rd_ready[k]));
            if (start_mac[k] && (fill_window_ready[k] || update_window_ready[k])) begin
                m_rd_ready[k] = 1'b1;
            end else if (32'(weight_channel[k]) == CH_LAST) begin
                m_rd_ready[k] = 1'b0;
            end
        end
    endtask

    task automatic step_frame();
        check_value(T_FRAME, 32'(m_frame_done), 32'(frame_done));
        if (m_frame_cnt == `CC_OUTPUT_SIZE) begin
            // a done in the pulse cycle is lost
            m_frame_cnt  = 0;
            m_frame_done = 1'b1;
            frames_seen++;
        end else begin
            m_frame_done = 1'b0;
            if (maxpool_done[N-1]) m_frame_cnt++;
        end
    endtask

    task automatic report_summary();
        if (read_passes == 0) begin
            $display("no read pass completed during the run");
            count_other();
        end
        if (write_bursts == 0) begin
            $display("no write burst completed during the run");
            count_other();
        end
        if (frames_seen == 0) begin
            $display("frame_done never pulsed during the stage phase");
            count_other();
        end
        $write("errors: read_order=%0d read_done_bank=%0d write_burst=%0d ",
               err_cnt[T_READ_ORDER], err_cnt[T_READ_DONE], err_cnt[T_WRITE]);
        $display("stage_enable=%0d rd_ready=%0d frame_done=%0d other=%0d total=%0d",
                 err_cnt[T_ENABLE], err_cnt[T_RDREADY], err_cnt[T_FRAME],
                 other_errs, total_errs);
    endtask

    // sampled on rising edges, before the DUT registers move
    always @(posedge clk) begin
        cycle++;
        if (rst_n) begin
            reset_model();
        end else if (end_of_test) begin
            report_summary();
        end else begin
            // stage model needs the first stage enable before this edge
            step_stages();
            step_read();
            step_write();
            step_frame();
        end
    end

endmodule

//--- conv_ctrl_config.svh
`ifndef CONV_CTRL_CONFIG_SVH
`define CONV_CTRL_CONFIG_SVH

// ----------------------------------------
// image geometry
// ----------------------------------------

// input images, read channel-interleaved
`define CC_NUM_IMAGES 4

// pixels per row and rows per image
// small values for simulation
`define CC_IMAGE_WIDTH 6
`define CC_IMAGE_HEIGHT 4

// ----------------------------------------
// convolution chain
// ----------------------------------------

// stages in the chain
`define CC_NUM_STAGES 6

// kernel rows per window
`define CC_KERNEL_SIZE 3

// rows each stage shifts through its window
`define CC_STAGE_ROWS 12

// weight channels per mac pass
`define CC_IN_CHANNELS 4

// last-stage completions per output frame
`define CC_OUTPUT_SIZE 12

`endif

//--- conv_ctrl_pkg.sv
package conv_ctrl_pkg;

    `include "conv_ctrl_config.svh"

    // ----------------------------------------
    // derived sizes
    // ----------------------------------------

    // pixels in one image
    localparam int IMAGE_SIZE = `CC_IMAGE_WIDTH * `CC_IMAGE_HEIGHT;

    // pixels across all images in one bank
    localparam int TOTAL_PIXELS = `CC_NUM_IMAGES * IMAGE_SIZE;

    // ----------------------------------------
    // fsm states
    // ----------------------------------------

    typedef enum logic {
        read_idle,
        read_active
    } read_state_e;

    typedef enum logic {
        write_idle,
        write_active
    } write_state_e;

    // ----------------------------------------
    // counter and address types
    // ----------------------------------------

    // pixel index inside one image
    typedef logic [$clog2(IMAGE_SIZE)-1:0] pix_t;
    // image index, innermost read counter
    typedef logic [$clog2(`CC_NUM_IMAGES)-1:0] img_t;
    // absolute bram address over all images
    typedef logic [$clog2(TOTAL_PIXELS)-1:0] abs_addr_t;
    // window shift count, up to stage rows
    typedef logic [$clog2(`CC_STAGE_ROWS+1)-1:0] shift_t;
    // weight channel index
    typedef logic [$clog2(`CC_IN_CHANNELS)-1:0] wch_t;
    // output frame counter, up to output size
    typedef logic [$clog2(`CC_OUTPUT_SIZE+1)-1:0] frame_cnt_t;

endpackage

//--- conv_ctrl_top.sv
`timescale 1ns/1ps

`include "conv_ctrl_config.svh"

module conv_ctrl_top (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic                                         start_read,
    input  logic                                         write_pixel_ready,
    input  logic                     [`CC_NUM_STAGES-1:0] maxpool_done,
    input  logic                     [`CC_NUM_STAGES-1:0] fifo_empty,
    input  conv_ctrl_pkg::shift_t    [`CC_NUM_STAGES-1:0] shift_count,
    input  logic                     [`CC_NUM_STAGES-1:0] start_mac,
    input  logic                     [`CC_NUM_STAGES-1:0] fill_window_ready,
    input  logic                     [`CC_NUM_STAGES-1:0] update_window_ready,
    input  conv_ctrl_pkg::wch_t      [`CC_NUM_STAGES-1:0] weight_channel,
    output logic                                         bram_read_en,
    output conv_ctrl_pkg::abs_addr_t                     bram_read_addr,
    output logic                                         pe_valid_in,
    output logic                                         pe_next_channel,
    output logic                                         first_stage_enable,
    output logic                                         read_done,
    output logic                                         bank_select,
    output logic                                         bram_write_en,
    output conv_ctrl_pkg::abs_addr_t                     bram_write_addr,
    output logic                     [`CC_NUM_STAGES-1:0] stage_enable,
    output logic                     [`CC_NUM_STAGES-1:0] rd_ready,
    output logic                                         frame_done
);

    import conv_ctrl_pkg::*;

    // done chain, bit k feeds stage k
    // top bit is the last stage's done
    logic [`CC_NUM_STAGES:0] done_chain;

    assign done_chain = {maxpool_done, first_stage_enable};

    // ----------------------------------------
    // bram sequencers
    // ----------------------------------------

    image_read_sequencer read_seq_i (
        .clk                (clk),
        .rst_n              (rst_n),
        .start_read         (start_read),
        .bram_read_en       (bram_read_en),
        .bram_read_addr     (bram_read_addr),
        .pe_valid_in        (pe_valid_in),
        .pe_next_channel    (pe_next_channel),
        .first_stage_enable (first_stage_enable),
        .read_done          (read_done),
        .bank_select        (bank_select)
    );

    image_write_sequencer write_seq_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .write_pixel_ready (write_pixel_ready),
        .bram_write_en     (bram_write_en),
        .bram_write_addr   (bram_write_addr)
    );

    // ----------------------------------------
    // per-stage gates
    // ----------------------------------------

    for (genvar g = 0; g < `CC_NUM_STAGES; g++) begin : g_stage
        stage_gate gate_i (
            .clk                 (clk),
            .rst_n               (rst_n),
            .upstream_done       (done_chain[g]),
            .fifo_empty          (fifo_empty[g]),
            .shift_count         (shift_count[g]),
            .start_mac           (start_mac[g]),
            .fill_window_ready   (fill_window_ready[g]),
            .update_window_ready (update_window_ready[g]),
            .weight_channel      (weight_channel[g]),
            .stage_enable        (stage_enable[g]),
            .rd_ready            (rd_ready[g])
        );
    end

    // last stage drains into the frame counter
    frame_tracker frame_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .last_maxpool_done (done_chain[`CC_NUM_STAGES]),
        .frame_done        (frame_done)
    );

endmodule

//--- frame_tracker.sv
`timescale 1ns/1ps

`include "conv_ctrl_config.svh"

module frame_tracker (
    input  logic clk,
    input  logic rst_n,
    input  logic last_maxpool_done,
    output logic frame_done
);

    import conv_ctrl_pkg::*;

    // completions in one output frame
    localparam frame_cnt_t FRAME_FULL = frame_cnt_t'(`CC_OUTPUT_SIZE);

    frame_cnt_t done_cnt;

    // ----------------------------------------
    // completion counter
    // ----------------------------------------

    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            done_cnt   <= '0;
            frame_done <= 1'b0;
        end else begin
            if (done_cnt == FRAME_FULL) begin
                // frame complete, pulse and restart
                // a done pulse here is dropped
                done_cnt   <= '0;
                frame_done <= 1'b1;
            end else begin
                frame_done <= 1'b0;
                // one count per high cycle
                if (last_maxpool_done) done_cnt <= done_cnt + 1'b1;
            end
        end
    end

endmodule

//--- image_read_sequencer.sv
`timescale 1ns/1ps

`include "conv_ctrl_config.svh"

module image_read_sequencer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start_read,
    output logic                    bram_read_en,
    output conv_ctrl_pkg::abs_addr_t bram_read_addr,
    output logic                    pe_valid_in,
    output logic                    pe_next_channel,
    output logic                    first_stage_enable,
    output logic                    read_done,
    output logic                    bank_select
);

    import conv_ctrl_pkg::*;

    // last values of the nested counters
    localparam img_t      IMG_LAST   = img_t'(`CC_NUM_IMAGES - 1);
    localparam pix_t      PIX_LAST   = pix_t'(IMAGE_SIZE - 1);
    // address stride between images
    localparam abs_addr_t IMG_STRIDE = abs_addr_t'(IMAGE_SIZE);

    read_state_e state_q;
    read_state_e state_d;
    img_t        img_cnt;
    pix_t        pix_cnt;
    // delayed done for bank edge detect
    logic        read_done_q;

    // ----------------------------------------
    // fsm and counters
    // ----------------------------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            read_idle: begin
                if (start_read) state_d = read_active;
            end
            read_active: begin
                // leave one cycle after done rises
                if (read_done) state_d = read_idle;
            end
            default: state_d = read_idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            state_q   <= read_idle;
            img_cnt   <= '0;
            pix_cnt   <= '0;
            read_done <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == read_idle && start_read) begin
                // fresh pass
                img_cnt   <= '0;
                pix_cnt   <= '0;
                read_done <= 1'b0;
            end else if (bram_read_en) begin
                // image index is innermost
                if (img_cnt == IMG_LAST) begin
                    img_cnt <= '0;
                    if (pix_cnt == PIX_LAST) begin
                        // last pixel of last image
                        pix_cnt   <= '0;
                        read_done <= 1'b1;
                    end else begin
                        pix_cnt <= pix_cnt + 1'b1;
                    end
                end else begin
                    img_cnt <= img_cnt + 1'b1;
                end
            end
        end
    end

    // ----------------------------------------
    // read strobes and address
    // ----------------------------------------

    // start_read low pauses reads, counters hold
    assign bram_read_en = (state_q == read_active) && start_read && !read_done;

    assign bram_read_addr = abs_addr_t'(img_cnt) * IMG_STRIDE + abs_addr_t'(pix_cnt);

    assign pe_valid_in = bram_read_en;
    // marks the last channel of a pixel
    assign pe_next_channel = bram_read_en && (img_cnt == IMG_LAST);

    // ----------------------------------------
    // first stage enable and ping-pong bank
    // ----------------------------------------

    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            first_stage_enable <= 1'b0;
            read_done_q        <= 1'b0;
            bank_select        <= 1'b0;
        end else begin
            // sticky after the first read ever
            if (bram_read_en) first_stage_enable <= 1'b1;
            read_done_q <= read_done;
            // one toggle per completed pass
            if (read_done && !read_done_q) bank_select <= ~bank_select;
        end
    end

endmodule

//--- image_write_sequencer.sv
`timescale 1ns/1ps

module image_write_sequencer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     write_pixel_ready,
    output logic                     bram_write_en,
    output conv_ctrl_pkg::abs_addr_t bram_write_addr
);

    import conv_ctrl_pkg::*;

    // last linear address of the burst
    localparam abs_addr_t ADDR_LAST = abs_addr_t'(TOTAL_PIXELS - 1);

    write_state_e state_q;
    write_state_e state_d;
    abs_addr_t    wr_cnt;

    // ----------------------------------------
    // fsm
    // ----------------------------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            write_idle: begin
                if (write_pixel_ready) state_d = write_active;
            end
            write_active: begin
                // burst ends on the last address
                if (wr_cnt == ADDR_LAST) state_d = write_idle;
            end
            default: state_d = write_idle;
        endcase
    end

    // linear counter over all images
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            state_q <= write_idle;
            wr_cnt  <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == write_idle && write_pixel_ready) begin
                wr_cnt <= '0;
            end else if (state_q == write_active && wr_cnt != ADDR_LAST) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
        end
    end

    // one write per active cycle, no back-pressure
    assign bram_write_en   = (state_q == write_active);
    assign bram_write_addr = wr_cnt;

endmodule

//--- stage_gate.sv
`timescale 1ns/1ps

`include "conv_ctrl_config.svh"

module stage_gate (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  upstream_done,
    input  logic                  fifo_empty,
    input  conv_ctrl_pkg::shift_t shift_count,
    input  logic                  start_mac,
    input  logic                  fill_window_ready,
    input  logic                  update_window_ready,
    input  conv_ctrl_pkg::wch_t   weight_channel,
    output logic                  stage_enable,
    output logic                  rd_ready
);

    import conv_ctrl_pkg::*;

    // window near the bottom of the stage rows
    localparam shift_t SHIFT_NEAR_END = shift_t'(`CC_STAGE_ROWS - `CC_KERNEL_SIZE);
    // one past, drain without new input
    localparam shift_t SHIFT_DRAIN    = shift_t'(`CC_STAGE_ROWS - `CC_KERNEL_SIZE + 1);
    // final weight channel of a mac pass
    localparam wch_t   WCH_LAST       = wch_t'(`CC_IN_CHANNELS - 1);

    logic window_ready;
    logic fifo_ready;

    // ----------------------------------------
    // stage enable
    // ----------------------------------------

    // input fifo has data for the last window rows
    assign fifo_ready = !fifo_empty && (shift_count >= SHIFT_NEAR_END);

    // zero latency, straight from the inputs
    assign stage_enable = upstream_done || fifo_ready || (shift_count == SHIFT_DRAIN);

    // ----------------------------------------
    // weight fifo read-ready latch
    // ----------------------------------------

    assign window_ready = fill_window_ready || update_window_ready;

    // held across one pass over all weight channels
    always_ff @(posedge clk or posedge rst_n) begin
        if (rst_n) begin
            rd_ready <= 1'b0;
        end else begin
            // set wins over clear
            if (start_mac && window_ready) begin
                rd_ready <= 1'b1;
            end else if (weight_channel == WCH_LAST) begin
                rd_ready <= 1'b0;
            end
        end
    end

endmodule

//--- tb_conv_ctrl.sv
`timescale 1ns/1ps

`include "conv_ctrl_config.svh"

module tb_conv_ctrl;

    import conv_ctrl_pkg::*;

    localparam int          N            = `CC_NUM_STAGES;
    localparam logic [31:0] SEED         = 32'h4330;
    localparam int          READ_PASSES  = 2;
    localparam int          WRITE_BURSTS = 2;
    localparam int          STAGE_CYCLES = 400;
    // two passes at ~130 cycles, two bursts at ~105, stage phase, then x2 margin
    localparam int          TIMEOUT_CYCLES = 2000;

    logic                  clk;
    logic                  rst_n;
    logic                  start_read;
    logic                  write_pixel_ready;
    logic          [N-1:0] maxpool_done;
    logic          [N-1:0] fifo_empty;
    shift_t        [N-1:0] shift_count;
    logic          [N-1:0] start_mac;
    logic          [N-1:0] fill_window_ready;
    logic          [N-1:0] update_window_ready;
    wch_t          [N-1:0] weight_channel;
    logic                  bram_read_en;
    abs_addr_t             bram_read_addr;
    logic                  pe_valid_in;
    logic                  pe_next_channel;
    logic                  first_stage_enable;
    logic                  read_done;
    logic                  bank_select;
    logic                  bram_write_en;
    abs_addr_t             bram_write_addr;
    logic          [N-1:0] stage_enable;
    logic          [N-1:0] rd_ready;
    logic                  frame_done;
    logic                  end_of_test;
    int                    error_count;
    logic           [31:0] rng_state;
    int                    cycle_cnt = 0;

    conv_ctrl_top dut_i (.*);

    conv_ctrl_checker chk_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // lcg, upper half of the state is the better random part
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state >> 16;
    endfunction

    // biased toward the two enable boundaries
    function automatic shift_t pick_shift();
        logic [31:0] r;
        r = next_rand();
        case (r % 4)
            0:       return shift_t'(`CC_STAGE_ROWS - `CC_KERNEL_SIZE);
            1:       return shift_t'(`CC_STAGE_ROWS - `CC_KERNEL_SIZE + 1);
            default: return shift_t'(next_rand() % (`CC_STAGE_ROWS + 1));
        endcase
    endfunction

    task automatic clear_inputs();
        start_read          = 1'b0;
        write_pixel_ready   = 1'b0;
        maxpool_done        = '0;
        fifo_empty          = '1;
        shift_count         = '0;
        start_mac           = '0;
        fill_window_ready   = '0;
        update_window_ready = '0;
        weight_channel      = '0;
    endtask

    // ----------------------------------------
    // stimulus phases
    // ----------------------------------------

    task automatic run_read_pass();
        start_read = 1'b1;
        @(negedge clk);
        // random drops of the level give back-pressure
        while (!read_done) begin
            start_read = (next_rand() % 4) != 0;
            @(negedge clk);
        end
        start_read = 1'b0;
        repeat (2 + next_rand() % 4) @(negedge clk);
    endtask

    task automatic run_write_burst();
        repeat (1 + next_rand() % 6) @(negedge clk);
        write_pixel_ready = 1'b1;
        @(negedge clk);
        write_pixel_ready = 1'b0;
        while (!bram_write_en) @(negedge clk);
        while (bram_write_en) @(negedge clk);
    endtask

    task automatic run_stage_phase();
        repeat (STAGE_CYCLES) begin
            for (int k = 0; k < N; k++) begin
                maxpool_done[k]        = (next_rand() % 3) == 0;
                fifo_empty[k]          = (next_rand() % 2) == 1;
                shift_count[k]         = pick_shift();
                start_mac[k]           = (next_rand() % 4) == 0;
                fill_window_ready[k]   = (next_rand() % 3) == 0;
                update_window_ready[k] = (next_rand() % 3) == 0;
                weight_channel[k]      = wch_t'(next_rand() % `CC_IN_CHANNELS);
            end
            @(negedge clk);
        end
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------

    initial begin
        rng_state   = SEED;
        rst_n       = 1'b1;
        end_of_test = 1'b0;
        clear_inputs();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b0;
        repeat (READ_PASSES) run_read_pass();
        repeat (WRITE_BURSTS) run_write_burst();
        run_stage_phase();
        clear_inputs();
        @(negedge clk);
        // checker prints its counts on the next rising edge
        end_of_test = 1'b1;
        @(negedge clk);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles without finishing the tests", cycle_cnt);
            $display("FAIL: see errors above");
            $finish;
        end
    end

endmodule
